// File: source/chiplet_rx_macros.svh
`ifndef CHIPLET_RX_MACROS_SVH
`define CHIPLET_RX_MACROS_SVH

// link word and receive cache geometry
`define FLIT_WIDTH 32
`define RX_DEPTH 64
`define RX_ADDR_WIDTH 6
`define PKT_LENGTH_WIDTH 4

// crc-32, msb first, no reflection, no final xor
`define CRC_POLY 32'h04C1_1DB7
`define CRC_INIT 32'hFFFF_FFFF

`endif

// File: source/chiplet_rx_pkg.sv
`include "chiplet_rx_macros.svh"

package chiplet_rx_pkg;

    // one link word
    typedef logic [`FLIT_WIDTH-1:0] flit_t;

    // requesting node, top nibble of the header
    typedef logic [3:0] node_id_t;

    // payload flit count, 1 to 15
    typedef logic [`PKT_LENGTH_WIDTH-1:0] pkt_length_t;

    // word address into the receive cache
    typedef logic [`RX_ADDR_WIDTH-1:0] cache_addr_t;

    // low bits of a header carry the payload length
    function automatic pkt_length_t header_length(input flit_t hdr);
        pkt_length_t len;
        len = hdr[`PKT_LENGTH_WIDTH-1:0];
        return len;
    endfunction

    // top bits of a header carry the requester id
    function automatic node_id_t header_node(input flit_t hdr);
        node_id_t node;
        node = hdr[`FLIT_WIDTH-1 -: $bits(node_id_t)];
        return node;
    endfunction

endpackage

// File: source/flit_counter.sv
`timescale 1ns/1ps

module flit_counter #(
    parameter int NBITS = 4
) (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             clear,
    input  logic             count_enable,
    input  logic [NBITS-1:0] limit,
    output logic [NBITS-1:0] count,
    output logic             done
);

    logic [NBITS-1:0] next_count;

    // clear wins over an enabled count
    always_comb begin
        next_count = count;
        if (clear) begin
            next_count = '0;
        end else if (count_enable) begin
            next_count = count + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

    // flags the programmed count
    assign done = (count == limit);

endmodule

// File: source/crc32_unit.sv
`timescale 1ns/1ps

`include "chiplet_rx_macros.svh"

module crc32_unit (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  crc_clear,
    input  logic                  crc_update,
    input  chiplet_rx_pkg::flit_t data,
    output logic [31:0]           crc_val
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // one word through 32 serial shift steps, msb of the word first
    function automatic logic [31:0] crc_fold(
        input logic [31:0]           crc_in,
        input chiplet_rx_pkg::flit_t word
    );
        logic [31:0] crc;
        logic        fb;
        crc = crc_in;
        for (int i = `FLIT_WIDTH - 1; i >= 0; i--) begin
            fb  = crc[31] ^ word[i];
            crc = {crc[30:0], 1'b0};
            if (fb) begin
                crc = crc ^ `CRC_POLY;
            end
        end
        return crc;
    endfunction

    always_comb begin
        crc_next = crc_q;
        if (crc_clear) begin
            crc_next = `CRC_INIT;
        end else if (crc_update) begin
            crc_next = crc_fold(crc_q, data);
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            crc_q <= `CRC_INIT;
        end else begin
            crc_q <= crc_next;
        end
    end

    // no final inversion
    assign crc_val = crc_q;

endmodule

// File: source/rx_cache.sv
`timescale 1ns/1ps

`include "chiplet_rx_macros.svh"

module rx_cache (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        wr_en,
    input  chiplet_rx_pkg::cache_addr_t wr_addr,
    input  chiplet_rx_pkg::flit_t       wr_data,
    input  chiplet_rx_pkg::cache_addr_t rd_addr,
    output chiplet_rx_pkg::flit_t       rd_data
);

    chiplet_rx_pkg::flit_t mem [`RX_DEPTH];

    // contents start out zeroed after reset
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `RX_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port is combinational, a write shows up after its edge
    assign rd_data = mem[rd_addr];

endmodule

// File: source/rx_fsm.sv
`timescale 1ns/1ps

module rx_fsm (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        flit_valid,
    input  chiplet_rx_pkg::flit_t       flit,
    input  logic [31:0]                 crc_val,
    input  logic                        done,
    output logic                        count_enable,
    output logic                        count_clear,
    output chiplet_rx_pkg::pkt_length_t count_limit,
    output logic                        crc_clear,
    output logic                        crc_update,
    output logic                        wr_en,
    output chiplet_rx_pkg::cache_addr_t wr_addr,
    output logic                        pkt_valid,
    output logic                        crc_error,
    output chiplet_rx_pkg::node_id_t    req,
    output chiplet_rx_pkg::cache_addr_t pkt_base,
    output chiplet_rx_pkg::pkt_length_t pkt_length
);

    typedef enum logic [1:0] {
        IDLE,
        PAYLOAD,
        CRC_WAIT,
        CHECK
    } state_e;

    state_e                      state, next_state;
    chiplet_rx_pkg::cache_addr_t next_wr_addr;
    logic                        crc_match;
    logic                        hdr_accept;

    assign hdr_accept = (state == IDLE) && flit_valid;

    always_comb begin
        next_state   = state;
        next_wr_addr = wr_addr;
        wr_en        = 1'b0;
        crc_update   = 1'b0;
        crc_clear    = 1'b0;
        count_enable = 1'b0;
        count_clear  = 1'b0;
        case (state)
            IDLE: begin
                if (flit_valid) begin
                    wr_en        = 1'b1;
                    crc_update   = 1'b1;
                    next_wr_addr = wr_addr + 1'b1;
                    next_state   = PAYLOAD;
                end
            end
            PAYLOAD: begin
                if (flit_valid) begin
                    wr_en        = 1'b1;
                    crc_update   = 1'b1;
                    count_enable = 1'b1;
                    next_wr_addr = wr_addr + 1'b1;
                    // done marks the last payload word
                    if (done) begin
                        next_state = CRC_WAIT;
                    end
                end
            end
            CRC_WAIT: begin
                // crc flit is compared only, never stored or folded
                if (flit_valid) begin
                    next_state = CHECK;
                end
            end
            CHECK: begin
                crc_clear   = 1'b1;
                count_clear = 1'b1;
                // bad packet gets overwritten by the next one
                if (!crc_match) begin
                    next_wr_addr = pkt_base;
                end
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= IDLE;
            wr_addr   <= '0;
            crc_match <= 1'b0;
        end else begin
            state   <= next_state;
            wr_addr <= next_wr_addr;
            if (state == CRC_WAIT && flit_valid) begin
                crc_match <= (flit == crc_val);
            end
        end
    end

    // header fields held until the next header
    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            req        <= chiplet_rx_pkg::header_node(flit);
            pkt_length <= chiplet_rx_pkg::header_length(flit);
            pkt_base   <= wr_addr;
        end
    end

    // counter starts at zero on the first payload word
    assign count_limit = pkt_length - 1'b1;

    assign pkt_valid = (state == CHECK) && crc_match;
    assign crc_error = (state == CHECK) && !crc_match;

endmodule

// File: source/chiplet_rx.sv
`timescale 1ns/1ps

`include "chiplet_rx_macros.svh"

module chiplet_rx (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        flit_valid,
    input  chiplet_rx_pkg::flit_t       flit,
    input  chiplet_rx_pkg::cache_addr_t rd_addr,
    output chiplet_rx_pkg::flit_t       rd_data,
    output logic                        pkt_valid,
    output logic                        crc_error,
    output chiplet_rx_pkg::node_id_t    req,
    output chiplet_rx_pkg::cache_addr_t pkt_base,
    output chiplet_rx_pkg::pkt_length_t pkt_length
);

    logic                        count_enable;
    logic                        count_clear;
    chiplet_rx_pkg::pkt_length_t count_limit;
    logic                        done;
    logic                        crc_clear;
    logic                        crc_update;
    logic [31:0]                 crc_val;
    logic                        wr_en;
    chiplet_rx_pkg::cache_addr_t wr_addr;

    rx_fsm rx_fsm_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .flit_valid   (flit_valid),
        .flit         (flit),
        .crc_val      (crc_val),
        .done         (done),
        .count_enable (count_enable),
        .count_clear  (count_clear),
        .count_limit  (count_limit),
        .crc_clear    (crc_clear),
        .crc_update   (crc_update),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .pkt_valid    (pkt_valid),
        .crc_error    (crc_error),
        .req          (req),
        .pkt_base     (pkt_base),
        .pkt_length   (pkt_length)
    );

    // payload word counter, running count is not needed here
    flit_counter #(
        .NBITS (`PKT_LENGTH_WIDTH)
    ) flit_counter_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .clear        (count_clear),
        .count_enable (count_enable),
        .limit        (count_limit),
        .count        (),
        .done         (done)
    );

    crc32_unit crc32_unit_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .data       (flit),
        .crc_val    (crc_val)
    );

    rx_cache rx_cache_i (
        .clk     (clk),
        .n_rst   (n_rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (flit),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: verif/chiplet_rx_tb.sv
`timescale 1ns/1ps

`include "chiplet_rx_macros.svh"

module chiplet_rx_tb;

    logic                        clk = 1'b0;
    logic                        n_rst;
    logic                        flit_valid;
    chiplet_rx_pkg::flit_t       flit;
    chiplet_rx_pkg::cache_addr_t rd_addr;
    chiplet_rx_pkg::flit_t       rd_data;
    logic                        pkt_valid;
    logic                        crc_error;
    chiplet_rx_pkg::node_id_t    req;
    chiplet_rx_pkg::cache_addr_t pkt_base;
    chiplet_rx_pkg::pkt_length_t pkt_length;

    // expected cache image and next packet base
    chiplet_rx_pkg::flit_t       model_mem [`RX_DEPTH];
    chiplet_rx_pkg::cache_addr_t exp_base;
    logic [31:0]                 lfsr_state = 32'd88208;
    int                          errors = 0;
    int                          n_good = 0;
    int                          n_bad = 0;

    chiplet_rx chiplet_rx_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .flit_valid (flit_valid),
        .flit       (flit),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .pkt_valid  (pkt_valid),
        .crc_error  (crc_error),
        .req        (req),
        .pkt_base   (pkt_base),
        .pkt_length (pkt_length)
    );

    always #5 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            r = {r[30:0], b};
        end
        return r;
    endfunction

    // reference crc with the word xored in before 32 shifts
    function automatic logic [31:0] crc_ref(input logic [31:0] crc_in, input logic [31:0] word);
        logic [31:0] c;
        c = crc_in ^ word;
        for (int i = 0; i < 32; i++) begin
            if (c[31]) begin
                c = (c << 1) ^ `CRC_POLY;
            end else begin
                c = c << 1;
            end
        end
        return c;
    endfunction

    task automatic log_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // no report may show up while a packet streams in
    task automatic check_quiet();
        if (pkt_valid !== 1'b0 || crc_error !== 1'b0) begin
            log_error("report output high while a packet is in flight");
        end
    endtask

    task automatic drive_flit(input chiplet_rx_pkg::flit_t word);
        check_quiet();
        flit_valid = 1'b1;
        flit = word;
        @(negedge clk);
    endtask

    // zero to three idle cycles
    task automatic insert_gap();
        logic [31:0] r;
        r = rand_bits(2);
        flit_valid = 1'b0;
        repeat (r[1:0]) begin
            check_quiet();
            @(negedge clk);
        end
    endtask

    task automatic send_packet(input chiplet_rx_pkg::node_id_t node,
                               input chiplet_rx_pkg::pkt_length_t len,
                               input logic corrupt, input logic gaps);
        chiplet_rx_pkg::flit_t       hdr;
        chiplet_rx_pkg::flit_t       word;
        chiplet_rx_pkg::cache_addr_t addr;
        logic [31:0]                 crc;
        logic [31:0]                 r;
        r = rand_bits(24);
        hdr = {node, r[23:0], len};
        crc = crc_ref(`CRC_INIT, hdr);
        addr = exp_base;
        model_mem[addr] = hdr;
        drive_flit(hdr);
        for (int i = 1; i <= len; i++) begin
            word = rand_bits(32);
            crc = crc_ref(crc, word);
            addr = addr + 1'b1;
            model_mem[addr] = word;
            if (gaps) begin
                insert_gap();
            end
            drive_flit(word);
        end
        if (gaps) begin
            insert_gap();
        end
        if (corrupt) begin
            r = rand_bits(5);
            crc = crc ^ (32'h1 << r[4:0]);
        end
        drive_flit(crc);
        flit_valid = 1'b0;
    endtask

    task automatic wait_report(output int cycles);
        int n;
        n = 0;
        while (!(pkt_valid || crc_error) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!(pkt_valid || crc_error)) begin
            $display("timeout: no packet report within 20 cycles at %0t ns", $time);
            $display("*** FAILED ***");
            $finish;
        end else begin
            cycles = n;
        end
    endtask

    task automatic check_report(input chiplet_rx_pkg::node_id_t node,
                                input chiplet_rx_pkg::pkt_length_t len, input logic corrupt);
        int cycles;
        wait_report(cycles);
        if (cycles != 0) begin
            log_error($sformatf("report %0d cycles late", cycles));
        end
        if (pkt_valid !== !corrupt || crc_error !== corrupt) begin
            log_error($sformatf("pkt_valid %b crc_error %b, corrupt %b", pkt_valid, crc_error,
                                corrupt));
        end
        if (req !== node || pkt_length !== len || pkt_base !== exp_base) begin
            log_error($sformatf("req %0d len %0d base %0d, expected %0d %0d %0d", req,
                                pkt_length, pkt_base, node, len, exp_base));
        end
        @(negedge clk);
        if (pkt_valid !== 1'b0 || crc_error !== 1'b0) begin
            log_error("report pulse longer than one cycle");
        end
        // only a good packet moves the write address on
        if (!corrupt) begin
            exp_base = exp_base + {2'b00, len} + 6'd1;
            n_good++;
        end else begin
            n_bad++;
        end
    endtask

    task automatic check_cache(input chiplet_rx_pkg::cache_addr_t start, input int count);
        chiplet_rx_pkg::cache_addr_t a;
        a = start;
        for (int i = 0; i < count; i++) begin
            rd_addr = a;
            @(negedge clk);
            if (rd_data !== model_mem[a]) begin
                log_error($sformatf("cache[%0d] = %h, expected %h", a, rd_data, model_mem[a]));
            end
            a = a + 1'b1;
        end
    endtask

    task automatic test_reset_idle();
        repeat (5) begin
            @(negedge clk);
            if (pkt_valid !== 1'b0 || crc_error !== 1'b0) begin
                log_error("report output high after reset");
            end
        end
    endtask

    task automatic test_good_packet();
        send_packet(4'd5, 4'd3, 1'b0, 1'b0);
        check_report(4'd5, 4'd3, 1'b0);
        check_cache(6'd0, 4);
    endtask

    // the good packet lands on the bad one's base
    task automatic test_bad_then_good();
        chiplet_rx_pkg::cache_addr_t base;
        base = exp_base;
        send_packet(4'd9, 4'd6, 1'b1, 1'b0);
        check_report(4'd9, 4'd6, 1'b1);
        send_packet(4'd2, 4'd2, 1'b0, 1'b0);
        check_report(4'd2, 4'd2, 1'b0);
        check_cache(base, 7);
    endtask

    task automatic test_gapped_packet();
        chiplet_rx_pkg::cache_addr_t base;
        base = exp_base;
        send_packet(4'd7, 4'd5, 1'b0, 1'b1);
        check_report(4'd7, 4'd5, 1'b0);
        check_cache(base, 6);
    endtask

    task automatic test_random_packets();
        chiplet_rx_pkg::cache_addr_t base;
        chiplet_rx_pkg::pkt_length_t len;
        chiplet_rx_pkg::node_id_t    node;
        logic [31:0]                 r;
        logic                        corrupt;
        logic                        gaps;
        logic                        wrapped;
        wrapped = 1'b0;
        for (int p = 0; p < 20; p++) begin
            r = rand_bits(4);
            len = (r[3:0] == 4'd0) ? 4'd1 : r[3:0];
            r = rand_bits(4);
            node = r[3:0];
            r = rand_bits(2);
            corrupt = (r[1:0] == 2'd0);
            r = rand_bits(1);
            gaps = r[0];
            base = exp_base;
            // packet words run past the last cache word
            if (int'(base) + int'(len) >= `RX_DEPTH) begin
                wrapped = 1'b1;
            end
            send_packet(node, len, corrupt, gaps);
            check_report(node, len, corrupt);
            check_cache(base, len + 1);
        end
        if (!wrapped) begin
            log_error("random packets never wrapped the cache address");
        end
    endtask

    initial begin
        n_rst = 1'b0;
        flit_valid = 1'b0;
        flit = '0;
        rd_addr = '0;
        exp_base = '0;
        for (int i = 0; i < `RX_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (10) @(negedge clk);
        n_rst = 1'b1;
        test_reset_idle();
        test_good_packet();
        test_bad_then_good();
        test_gapped_packet();
        test_random_packets();
        check_cache(6'd0, `RX_DEPTH);
        $display("packets good %0d bad %0d, errors %0d", n_good, n_bad, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: chiplet_rx.f
+incdir+source
source/chiplet_rx_pkg.sv
source/flit_counter.sv
source/crc32_unit.sv
source/rx_cache.sv
source/rx_fsm.sv
source/chiplet_rx.sv
verif/chiplet_rx_tb.sv

// File: Bender.yml
package:
  name: chiplet_rx

sources:
  - include_dirs:
      - source
    files:
      - source/chiplet_rx_pkg.sv
      - source/flit_counter.sv
      - source/crc32_unit.sv
      - source/rx_cache.sv
      - source/rx_fsm.sv
      - source/chiplet_rx.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/chiplet_rx_tb.sv
